// ==== cache_geometry_pkg.sv ====
package cache_geometry_pkg;

    localparam int addr_width   = 64;
    localparam int word_width   = 64;  // CPU data path
    localparam int line_count   = 64;
    localparam int line_bytes   = 64;
    localparam int offset_width = $clog2(line_bytes);
    localparam int index_width  = $clog2(line_count);
    localparam int tag_width    = addr_width - index_width - offset_width;
    localparam int line_width   = line_bytes * 8;

    typedef logic [line_width-1:0]  line_data_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [index_width-1:0] line_index_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    // Address field extraction
    function automatic line_index_t addr_index(input logic [addr_width-1:0] addr);
        return addr[offset_width +: index_width];
    endfunction

    function automatic tag_t addr_tag(input logic [addr_width-1:0] addr);
        return addr[addr_width-1 -: tag_width];
    endfunction

    function automatic logic [offset_width-1:0] addr_offset(input logic [addr_width-1:0] addr);
        return addr[offset_width-1:0];
    endfunction

    // Line aligned address from its tag and index
    function automatic logic [addr_width-1:0] line_base(input tag_t tag, input line_index_t index);
        return {tag, index, {offset_width{1'b0}}};
    endfunction

endpackage

// ==== cache_protocol_pkg.sv ====
package cache_protocol_pkg;

    // Store size encoding, low two bits of the CPU size field
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } access_size_t;

    typedef enum logic [2:0] {
        idle,          // Waiting for a read miss or a store
        read_miss,     // Refill running for the CPU read
        store_lookup,  // Tag check of the latched store
        store_miss,    // Allocating the store line
        store_done     // Completion pulse
    } ctrl_state_t;

    // Number of bytes written by one store
    function automatic int size_bytes(input access_size_t size);
        case (size)
            size_byte:   return 1;
            size_half:   return 2;
            size_word:   return 4;
            default:     return 8;
        endcase
    endfunction

endpackage

// ==== l2_channel_if.sv ====
`timescale 1ns/1ns

// One engine's request path toward the shared L2 port
interface l2_channel_if import cache_geometry_pkg::*; ();

    logic                  valid;  // Held until done
    logic                  write;  // 1 for a line write-back, 0 for a refill read
    logic [addr_width-1:0] addr;
    line_data_t            wdata;
    line_data_t            rdata;  // Valid during the done pulse of a read
    logic                  done;

    modport engine (
        output valid, write, addr, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  valid, write, addr, wdata,
        output rdata, done
    );

endinterface

// ==== line_store.sv ====
`timescale 1ns/1ns

module line_store import cache_geometry_pkg::*, cache_protocol_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_width-1:0] read_addr,
    output logic [word_width-1:0] read_data,
    output logic                  read_hit,
    input  line_index_t           lookup_index,
    output line_meta_t            lookup_meta,
    output line_data_t            lookup_line,
    input  logic                  fill_en,
    input  line_index_t           fill_index,
    input  tag_t                  fill_tag,
    input  line_data_t            fill_line,
    input  logic                  merge_en,
    input  logic [addr_width-1:0] merge_addr,
    input  logic [word_width-1:0] merge_data,
    input  access_size_t          merge_size
);
    logic [line_count-1:0]   valid_q;
    logic [line_count-1:0]   dirty_q;
    tag_t                    tag_q [line_count];
    line_data_t              data_q [line_count];
    line_index_t             read_index;
    line_index_t             merge_index;
    logic [offset_width-1:0] read_offset;
    logic [offset_width-1:0] merge_offset;
    line_data_t              merged_line;

    assign read_index   = addr_index(read_addr);
    assign read_offset  = addr_offset(read_addr);
    assign merge_index  = addr_index(merge_addr);
    assign merge_offset = addr_offset(merge_addr);

    // Read port, 8 bytes from the byte offset
    assign read_hit  = valid_q[read_index] && (tag_q[read_index] == addr_tag(read_addr));
    assign read_data = data_q[read_index][{read_offset, 3'b000} +: word_width];

    assign lookup_meta = '{valid: valid_q[lookup_index], dirty: dirty_q[lookup_index],
                           tag: tag_q[lookup_index]};
    assign lookup_line = data_q[lookup_index];

    // Overlay the sized store bytes onto the resident line
    always_comb begin
        merged_line = data_q[merge_index];
        for (int b = 0; b < word_width / 8; b++) begin
            if (b < size_bytes(merge_size) && int'(merge_offset) + b < line_bytes) begin
                merged_line[(int'(merge_offset) + b) * 8 +: 8] = merge_data[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_index] <= 1'b1;  // Refilled lines start clean
            dirty_q[fill_index] <= 1'b0;
        end else if (merge_en) begin
            dirty_q[merge_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_line;
        end else if (merge_en) begin
            data_q[merge_index] <= merged_line;
        end
    end

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ns

module cache_controller import cache_geometry_pkg::*, cache_protocol_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_addr_valid,
    input  logic                  read_hit,
    input  logic [addr_width-1:0] read_addr,
    output logic                  read_data_valid,
    input  logic                  store_valid,
    input  logic [addr_width-1:0] store_addr,
    input  logic [word_width-1:0] store_data,
    input  logic [3:0]            store_size,
    output logic                  store_ready,
    output logic                  store_complete,
    output line_index_t           lookup_index,
    input  line_meta_t            lookup_meta,
    input  line_data_t            lookup_line,
    output logic                  merge_en,
    output logic [addr_width-1:0] merge_addr,
    output logic [word_width-1:0] merge_data,
    output access_size_t          merge_size,
    output logic                  refill_start,
    output logic [addr_width-1:0] refill_addr,
    input  logic                  refill_done,
    output logic                  evict_start,
    output logic [addr_width-1:0] evict_addr,
    output line_data_t            evict_line
);
    ctrl_state_t           state;
    ctrl_state_t           next_state;
    logic                  st_pending;  // A store is held until its completion
    logic [addr_width-1:0] st_addr;
    logic [word_width-1:0] st_data;
    access_size_t          st_size;
    logic                  store_accept;
    logic                  read_miss_now;
    logic                  use_read_index;
    logic                  victim_dirty;
    logic                  store_hit;

    assign store_ready     = !st_pending;
    assign store_accept    = store_valid && store_ready;
    assign read_miss_now   = read_addr_valid && !read_hit;
    assign read_data_valid = read_addr_valid && read_hit;

    // The read miss takes the lookup port only while idle
    assign use_read_index = (state == idle) && read_miss_now;
    assign lookup_index   = use_read_index ? addr_index(read_addr) : addr_index(st_addr);

    assign victim_dirty = lookup_meta.valid && lookup_meta.dirty;
    assign store_hit    = lookup_meta.valid && (lookup_meta.tag == addr_tag(st_addr));

    assign refill_addr = use_read_index ? read_addr : st_addr;
    assign evict_addr  = line_base(lookup_meta.tag, lookup_index);
    assign evict_line  = lookup_line;

    assign merge_addr = st_addr;
    assign merge_data = st_data;
    assign merge_size = st_size;

    always_comb begin
        next_state     = state;
        refill_start   = 1'b0;
        evict_start    = 1'b0;
        merge_en       = 1'b0;
        store_complete = 1'b0;
        case (state)
            idle: begin
                if (read_miss_now) begin  // Reads go ahead of a pending store
                    refill_start = 1'b1;
                    evict_start  = victim_dirty;
                    next_state   = read_miss;
                end else if (st_pending || store_accept) begin
                    next_state = store_lookup;
                end
            end
            read_miss: begin
                if (refill_done) next_state = idle;
            end
            store_lookup: begin
                if (store_hit) begin
                    merge_en   = 1'b1;
                    next_state = store_done;
                end else begin
                    // Allocate, victim leaves through the write-back engine
                    refill_start = 1'b1;
                    evict_start  = victim_dirty;
                    next_state   = store_miss;
                end
            end
            store_miss: begin
                if (refill_done) next_state = store_lookup;  // Hits on the second pass
            end
            store_done: begin
                store_complete = 1'b1;
                next_state     = idle;
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            st_pending <= 1'b0;
        end else begin
            state <= next_state;
            if (store_accept) begin
                st_pending <= 1'b1;
            end else if (state == store_done) begin
                st_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_accept) begin
            st_addr <= store_addr;
            st_data <= store_data;
            st_size <= access_size_t'(store_size[1:0]);  // Upper size bits ignored
        end
    end

endmodule

// ==== refill_engine.sv ====
`timescale 1ns/1ns

module refill_engine import cache_geometry_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [addr_width-1:0] addr,
    output logic                  fill_en,
    output line_index_t           fill_index,
    output tag_t                  fill_tag,
    output line_data_t            fill_line,
    output logic                  done,
    l2_channel_if.engine          ch
);
    logic                  busy;
    logic [addr_width-1:0] line_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (ch.done) begin
            busy <= 1'b0;  // Valid drops the cycle after done
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            line_addr <= {addr[addr_width-1:offset_width], {offset_width{1'b0}}};
        end
    end

    // Read request held while busy
    assign ch.valid = busy;
    assign ch.write = 1'b0;
    assign ch.addr  = line_addr;
    assign ch.wdata = '0;

    // Line data is only valid during the done pulse
    assign fill_en    = busy && ch.done;
    assign fill_index = addr_index(line_addr);
    assign fill_tag   = addr_tag(line_addr);
    assign fill_line  = ch.rdata;
    assign done       = fill_en;

endmodule

// ==== writeback_engine.sv ====
`timescale 1ns/1ns

module writeback_engine import cache_geometry_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [addr_width-1:0] addr,
    input  line_data_t            line,
    l2_channel_if.engine          ch
);
    logic                  busy;
    logic [addr_width-1:0] victim_addr;
    line_data_t            victim_line;  // Copy of the evicted line

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (ch.done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            victim_addr <= addr;
            victim_line <= line;
        end
    end

    assign ch.valid = busy;
    assign ch.write = 1'b1;
    assign ch.addr  = victim_addr;
    assign ch.wdata = victim_line;

endmodule

// ==== l2_arbiter.sv ====
`timescale 1ns/1ns

module l2_arbiter import cache_geometry_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    l2_channel_if.arbiter         wb_ch,
    l2_channel_if.arbiter         refill_ch,
    output logic                  l2_valid,
    output logic                  l2_write,
    output logic [addr_width-1:0] l2_addr,
    output line_data_t            l2_wdata,
    input  line_data_t            l2_rdata,
    input  logic                  l2_done
);
    logic held;     // A transfer owns the port
    logic held_wb;  // Owner of the held transfer
    logic grant_wb;
    logic grant_refill;

    // Write-back first, so a victim is out before its replacement lands
    always_comb begin
        if (held) begin
            grant_wb     = held_wb;
            grant_refill = !held_wb;
        end else begin
            grant_wb     = wb_ch.valid;
            grant_refill = !wb_ch.valid && refill_ch.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held    <= 1'b0;
            held_wb <= 1'b0;
        end else if (l2_done) begin
            held <= 1'b0;
        end else if (grant_wb || grant_refill) begin
            held    <= 1'b1;
            held_wb <= grant_wb;
        end
    end

    assign l2_valid = (grant_wb && wb_ch.valid) || (grant_refill && refill_ch.valid);
    assign l2_write = grant_wb ? wb_ch.write : refill_ch.write;
    assign l2_addr  = grant_wb ? wb_ch.addr : refill_ch.addr;
    assign l2_wdata = grant_wb ? wb_ch.wdata : refill_ch.wdata;

    // Completion only reaches the engine that owns the port
    assign wb_ch.rdata     = l2_rdata;
    assign wb_ch.done      = grant_wb && l2_done;
    assign refill_ch.rdata = l2_rdata;
    assign refill_ch.done  = grant_refill && l2_done;

endmodule

// ==== l1_dcache.sv ====
`timescale 1ns/1ns

module l1_dcache import cache_geometry_pkg::*, cache_protocol_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_width-1:0] read_addr,
    input  logic                  read_addr_valid,
    output logic [word_width-1:0] read_data,
    output logic                  read_data_valid,
    input  logic                  store_valid,
    input  logic [addr_width-1:0] store_addr,
    input  logic [word_width-1:0] store_data,
    input  logic [3:0]            store_size,
    output logic                  store_ready,
    output logic                  store_complete,
    output logic                  l2_valid,
    output logic                  l2_write,
    output logic [addr_width-1:0] l2_addr,
    output line_data_t            l2_wdata,
    input  line_data_t            l2_rdata,
    input  logic                  l2_done
);
    logic                  read_hit;
    line_index_t           lookup_index;
    line_meta_t            lookup_meta;
    line_data_t            lookup_line;
    logic                  fill_en;
    line_index_t           fill_index;
    tag_t                  fill_tag;
    line_data_t            fill_line;
    logic                  merge_en;
    logic [addr_width-1:0] merge_addr;
    logic [word_width-1:0] merge_data;
    access_size_t          merge_size;
    logic                  refill_start;
    logic [addr_width-1:0] refill_addr;
    logic                  refill_done;
    logic                  evict_start;
    logic [addr_width-1:0] evict_addr;
    line_data_t            evict_line;

    l2_channel_if refill_ch ();
    l2_channel_if writeback_ch ();

    line_store u_line_store (
        .clk, .reset, .read_addr, .read_data, .read_hit,
        .lookup_index, .lookup_meta, .lookup_line,
        .fill_en, .fill_index, .fill_tag, .fill_line,
        .merge_en, .merge_addr, .merge_data, .merge_size
    );

    cache_controller u_controller (
        .clk, .reset, .read_addr_valid, .read_hit, .read_addr, .read_data_valid,
        .store_valid, .store_addr, .store_data, .store_size, .store_ready, .store_complete,
        .lookup_index, .lookup_meta, .lookup_line,
        .merge_en, .merge_addr, .merge_data, .merge_size,
        .refill_start, .refill_addr, .refill_done,
        .evict_start, .evict_addr, .evict_line
    );

    refill_engine u_refill (
        .clk, .reset, .start(refill_start), .addr(refill_addr),
        .fill_en, .fill_index, .fill_tag, .fill_line, .done(refill_done),
        .ch(refill_ch.engine)
    );

    writeback_engine u_writeback (
        .clk, .reset, .start(evict_start), .addr(evict_addr), .line(evict_line),
        .ch(writeback_ch.engine)
    );

    l2_arbiter u_arbiter (
        .clk, .reset,
        .wb_ch(writeback_ch.arbiter), .refill_ch(refill_ch.arbiter),
        .l2_valid, .l2_write, .l2_addr, .l2_wdata, .l2_rdata, .l2_done
    );

endmodule

// ==== l2_memory_model.sv ====
`timescale 1ns/1ns

// Next-level memory behind the shared L2 port, with a random delay per transfer
module l2_memory_model import cache_geometry_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  l2_valid,
    input  logic                  l2_write,
    input  logic [addr_width-1:0] l2_addr,
    input  line_data_t            l2_wdata,
    output line_data_t            l2_rdata,
    output logic                  l2_done,
    output int                    writeback_count
);
    logic [word_width-1:0] written [logic [addr_width-1:0]];  // Words received by write-backs
    integer                seed = 85890;
    logic                  active;  // A request is being served
    int                    delay;

    // Background content unless a write-back replaced the word
    function automatic logic [word_width-1:0] word_at(input logic [addr_width-1:0] addr);
        if (written.exists(addr)) begin
            return written[addr];
        end
        return addr ^ 64'hA5A5_A5A5_A5A5_A5A5;
    endfunction

    initial begin
        l2_done  = 1'b0;
        l2_rdata = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            active          <= 1'b0;
            l2_done         <= 1'b0;
            writeback_count <= 0;
        end else if (l2_done) begin
            l2_done <= 1'b0;  // Requester drops valid in this cycle
            active  <= 1'b0;
        end else if (active) begin
            if (delay > 1) begin
                delay <= delay - 1;
            end else begin
                l2_done <= 1'b1;
                for (int w = 0; w < line_bytes / 8; w++) begin
                    if (l2_write) begin
                        written[l2_addr + 64'(w * 8)] = l2_wdata[w * 64 +: 64];
                    end else begin
                        l2_rdata[w * 64 +: 64] <= word_at(l2_addr + 64'(w * 8));
                    end
                end
                if (l2_write) writeback_count <= writeback_count + 1;
            end
        end else if (l2_valid) begin
            active <= 1'b1;
            delay  <= 1 + int'({$random(seed)} % 8);  // 1 to 8 cycles
        end
    end

endmodule

// ==== tb_l1_dcache.sv ====
`timescale 1ns/1ns

module tb_l1_dcache import cache_geometry_pkg::*, cache_protocol_pkg::*; ();

    localparam int max_ops      = 64;
    localparam int golden_words = max_ops * 4;  // Op, address, data, size per line
    localparam int op_read      = 1;
    localparam int op_read_hit  = 2;  // Read that must hit at once
    localparam int op_write     = 3;
    localparam int op_wb_count  = 4;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] read_addr;
    logic                  read_addr_valid;
    logic [word_width-1:0] read_data;
    logic                  read_data_valid;
    logic                  store_valid;
    logic [addr_width-1:0] store_addr;
    logic [word_width-1:0] store_data;
    logic [3:0]            store_size;
    logic                  store_ready;
    logic                  store_complete;
    logic                  l2_valid;
    logic                  l2_write;
    logic [addr_width-1:0] l2_addr;
    line_data_t            l2_wdata;
    line_data_t            l2_rdata;
    logic                  l2_done;
    int                    writeback_count;
    logic [63:0]           golden [golden_words];
    int                    op_count;
    logic                  ops_loaded = 1'b0;

    l1_dcache DUT (.*);

    l2_memory_model u_l2_memory (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_word(input string name, input logic [word_width-1:0] actual,
                              input logic [word_width-1:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "handshake mismatch");
        end
    endtask

    // Holds the address until read_data_valid
    task automatic read_and_check(input logic [addr_width-1:0] addr,
                                  input logic [word_width-1:0] expected, input logic must_hit);
        @(negedge clk);
        read_addr       = addr;
        read_addr_valid = 1'b1;
        #1;
        if (must_hit) compare_bit("read_data_valid", read_data_valid, 1'b1);
        while (!read_data_valid) @(negedge clk);
        check_word("read_data", read_data, expected);
        @(negedge clk);
        read_addr_valid = 1'b0;
    endtask

    task automatic issue_store(input logic [addr_width-1:0] addr,
                               input logic [word_width-1:0] data, input access_size_t size);
        @(negedge clk);
        compare_bit("store_ready", store_ready, 1'b1);
        store_valid = 1'b1;
        store_addr  = addr;
        store_data  = data;
        store_size  = {2'b00, size};
        @(negedge clk);
        store_valid = 1'b0;  // Accepted at the edge just passed
        while (!store_complete) begin
            compare_bit("store_ready", store_ready, 1'b0);
            @(negedge clk);
        end
        compare_bit("store_ready", store_ready, 1'b0);
        @(negedge clk);
        compare_bit("store_ready", store_ready, 1'b1);
        compare_bit("store_complete", store_complete, 1'b0);  // One-cycle pulse
    endtask

    initial begin
        int                    idx;
        logic [63:0]           op;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] data;
        logic [63:0]           size_field;

        reset           = 1'b1;
        read_addr       = '0;
        read_addr_valid = 1'b0;
        store_valid     = 1'b0;
        store_addr      = '0;
        store_data      = '0;
        store_size      = '0;
        for (idx = 0; idx < golden_words; idx++) golden[idx] = '0;
        $readmemh("l1_dcache_golden.txt", golden);
        op_count = 0;
        while (op_count < max_ops && golden[op_count * 4] != '0) begin
            op_count++;
        end
        if (op_count == 0) begin
            $display("The golden file holds no operations");
            $display("Regression failed");
            $fatal(1, "empty golden file");
        end
        ops_loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_bit("store_ready", store_ready, 1'b1);

        for (idx = 0; idx < op_count; idx++) begin
            op         = golden[idx * 4];
            addr       = golden[idx * 4 + 1];
            data       = golden[idx * 4 + 2];
            size_field = golden[idx * 4 + 3];
            case (int'(op))
                op_read:     read_and_check(addr, data, 1'b0);
                op_read_hit: read_and_check(addr, data, 1'b1);
                op_write:    issue_store(addr, data, access_size_t'(size_field[1:0]));
                op_wb_count: check_count("writeback_count", writeback_count, int'(data));
                default: begin
                    $display("Unknown operation code %0h in the golden file", op);
                    $display("Regression failed");
                    $fatal(1, "bad golden line");
                end
            endcase
        end
        $display("Regression passed");
        $finish;
    end

    // Budget of 200 cycles for every golden line
    initial begin
        wait (ops_loaded);
        repeat (200 * op_count) @(posedge clk);
        $display("Timeout: the cache did not finish the golden operations in time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== l1_dcache_golden.txt ====
// Columns: op (1 read, 2 read that must hit, 3 store, 4 write-back count), address,
// data (expected read value, store value or expected count), store size (0 to 3)
1 1040 A5A5A5A5A5A5B5E5 0
2 1040 A5A5A5A5A5A5B5E5 0
2 1048 A5A5A5A5A5A5B5ED 0
3 1041 000000000000003C 0
2 1040 A5A5A5A5A5A53CE5 0
3 1052 000000000000BEEF 1
2 1050 A5A5A5A5BEEFB5F5 0
3 1058 0000000012345678 2
2 1058 A5A5A5A512345678 0
3 1060 0123456789ABCDEF 3
2 1060 0123456789ABCDEF 0
2 1054 12345678A5A5A5A5 0
3 2084 00000000DEADBEEF 2
2 2080 DEADBEEFA5A58525 0
2 2088 A5A5A5A5A5A5852D 0
4 0 0000000000000000 0
1 5040 A5A5A5A5A5A5F5E5 0
4 0 0000000000000001 0
1 1040 A5A5A5A5A5A53CE5 0
4 0 0000000000000001 0
2 1060 0123456789ABCDEF 0
2 1054 12345678A5A5A5A5 0
1 6040 A5A5A5A5A5A5C5E5 0
4 0 0000000000000001 0
1 3080 A5A5A5A5A5A59525 0
4 0 0000000000000002 0
1 2084 A5A5852DDEADBEEF 0
3 70BF 000000000000005A 0
4 0 0000000000000002 0
3 2086 0000000000001234 1
4 0 0000000000000003 0
2 2080 1234BEEFA5A58525 0
1 70B8 5AA5A5A5A5A5D51D 0
4 0 0000000000000004 0

// ==== l1_dcache.f ====
cache_geometry_pkg.sv
cache_protocol_pkg.sv
l2_channel_if.sv
line_store.sv
cache_controller.sv
refill_engine.sv
writeback_engine.sv
l2_arbiter.sv
l1_dcache.sv
l2_memory_model.sv
tb_l1_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_l1_dcache \
    -f l1_dcache.f -o tb_l1_dcache
./obj_dir/tb_l1_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1
